// File: hdl/mpu_consts.svh
////////////////////////////////////////////////////////////
// MPU external data service constants
// Word, address, memory and buffer sizing
////////////////////////////////////////////////////////////

`ifndef MPU_CONSTS_SVH
`define MPU_CONSTS_SVH

// Data word width in bits
`define MPU_WIDTH_DATA	32

// Memory address width, also used for stride and length
`define MPU_WIDTH_ADDR	8

`define MPU_MEM_DEPTH	256		// Words in data memory

`define MPU_BUFF_SIZE	16		// Default ring buffer depth

`endif

// File: hdl/mpu_pkg.sv
////////////////////////////////////////////////////////////
// MPU external data service package
// Shared word types and state machine encodings
////////////////////////////////////////////////////////////

`include "mpu_consts.svh"

package mpu_pkg;

	typedef logic [`MPU_WIDTH_DATA-1:0]	data_t;
	typedef logic [`MPU_WIDTH_ADDR-1:0]	addr_t;	// Address, stride, length

	// Opcode word bit 0 selects the command
	typedef enum logic {
		OP_STORE	= 1'b0,
		OP_LOAD		= 1'b1
	} op_t;

	// Command header reception
	typedef enum logic [2:0] {
		SERV_INIT,
		SERV_RECV_STRIDE,
		SERV_RECV_LENGTH,
		SERV_RECV_BASE,
		SERV_RUN
	} fsm_serv_t;

	// Store path, extern to memory
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUFF,		// Collect words from extern
		ST_WAIT,		// Wait for memory grant
		ST_RUN			// Drain buffer to memory
	} fsm_st_t;

	// Load path, memory to extern
	typedef enum logic [1:0] {
		LD_IDLE,
		LD_WAIT,
		LD_RUN
	} fsm_ld_t;

	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_STORE,
		MEM_LOAD
	} fsm_mem_t;

endpackage

// File: hdl/mem_port_if.sv
////////////////////////////////////////////////////////////
// Memory port between data service and data memory
// Request, grant and terminate strobes for load and store
////////////////////////////////////////////////////////////

interface mem_port_if
	import mpu_pkg::*;
();

	// Service side
	logic	st_req;			// Level until st_term
	logic	ld_req;			// Level until ld_term
	addr_t	base;
	addr_t	stride;
	addr_t	length;
	data_t	st_data;

	// Memory side
	logic	st_grant;
	logic	ld_grant;
	logic	ld_valid;
	data_t	ld_data;
	logic	st_term;		// With last write
	logic	ld_term;		// With last word

	modport service (
		output	st_req, ld_req, base, stride, length, st_data,
		input	st_grant, ld_grant, ld_valid, ld_data, st_term, ld_term
	);

	modport memory (
		input	st_req, ld_req, base, stride, length, st_data,
		output	st_grant, ld_grant, ld_valid, ld_data, st_term, ld_term
	);

endinterface

// File: hdl/ring_buff_ctrl.sv
////////////////////////////////////////////////////////////
// Ring buffer controller
// Write and read pointers with occupancy count and flags
////////////////////////////////////////////////////////////

module ring_buff_ctrl #(
	parameter int NUM_ENTRY = 16		// Power of two, at least 4
)(
	input	logic					clock,
	input	logic					reset,
	input	logic					we,
	input	logic					re,
	output	logic [$clog2(NUM_ENTRY)-1:0]	wr_ptr,
	output	logic [$clog2(NUM_ENTRY)-1:0]	rd_ptr,
	output	logic [$clog2(NUM_ENTRY):0]	num,
	output	logic					full,
	output	logic					empty
);

	localparam int WIDTH_PTR = $clog2(NUM_ENTRY);

	assign full		= num == (WIDTH_PTR+1)'(NUM_ENTRY);
	assign empty	= num == '0;

	// Pointers wrap on their own width
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
		end
		else begin
			if (we) begin
				wr_ptr	<= wr_ptr + 1'b1;
			end
			if (re) begin
				rd_ptr	<= rd_ptr + 1'b1;
			end
		end
	end

	// Occupancy
	always_ff @(posedge clock) begin
		if (reset) begin
			num	<= '0;
		end
		else begin
			case ({we, re})
				2'b10:		num	<= num + 1'b1;
				2'b01:		num	<= num - 1'b1;
				default:	num	<= num;		// Both or neither
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Overflow unless a read frees a slot in the same cycle
	a_no_overflow: assert property (@(posedge clock) disable iff (reset)
		we |-> (!full || re));

	a_no_underflow: assert property (@(posedge clock) disable iff (reset)
		re |-> !empty);

endmodule

// File: hdl/extern_data_service.sv
////////////////////////////////////////////////////////////
// External data service
// Decodes four-word commands and moves strided blocks
// between the external port and data memory through a
// ring buffer
////////////////////////////////////////////////////////////

`include "mpu_consts.svh"

module extern_data_service
	import mpu_pkg::*;
#(
	parameter int BUFF_SIZE = `MPU_BUFF_SIZE
)(
	input	logic			clock,
	input	logic			reset,
	input	logic			ext_req,		// Word strobe from extern
	input	data_t			ext_data,
	output	logic			ext_out_req,	// Word strobe to extern
	output	data_t			ext_out_data,
	output	logic			busy,
	output	logic			done,			// End of command
	mem_port_if.service		mem
);

	localparam int WIDTH_BUFF = $clog2(BUFF_SIZE);

	fsm_serv_t				serv_state;
	fsm_st_t				st_state;
	fsm_ld_t				ld_state;

	// Command header
	op_t					op_r;
	addr_t					stride_r;
	addr_t					length_r;
	addr_t					base_r;

	logic					cmd_start;
	logic					fill_word;
	logic					fill_last;
	logic					st_fin;
	logic					ld_fin;
	logic					ld_term_seen;

	// Buffer
	data_t					buff [BUFF_SIZE];
	data_t					buff_in;
	logic					we;
	logic					re;
	logic [WIDTH_BUFF-1:0]	wr_ptr;
	logic [WIDTH_BUFF-1:0]	rd_ptr;
	logic [WIDTH_BUFF:0]	num;
	logic					full;
	logic					empty;

	assign cmd_start	= (serv_state == SERV_RECV_BASE) && ext_req;	// Base word
	assign fill_word	= (st_state == ST_BUFF) && ext_req && !full;
	assign fill_last	= fill_word && (addr_t'(num) + addr_t'(1) == length_r);
	assign st_fin		= (st_state == ST_RUN) && mem.st_term;
	assign ld_fin		= (ld_state == LD_RUN) && ld_term_seen && empty;

	assign busy			= serv_state != SERV_INIT;

	////////////////////////////////////////////////////////////
	// Buffer and ring pointers
	////////////////////////////////////////////////////////////

	assign we		= fill_word || ((ld_state == LD_RUN) && mem.ld_valid);
	assign re		= (st_state == ST_RUN) || ext_out_req;
	assign buff_in	= fill_word ? ext_data : mem.ld_data;

	always_ff @(posedge clock) begin
		if (we) begin
			buff[wr_ptr]	<= buff_in;
		end
	end

	ring_buff_ctrl #(
		.NUM_ENTRY	(BUFF_SIZE)
	) u_ring_buff_ctrl (
		.clock		(clock),
		.reset		(reset),
		.we			(we),
		.re			(re),
		.wr_ptr		(wr_ptr),
		.rd_ptr		(rd_ptr),
		.num		(num),
		.full		(full),
		.empty		(empty)
	);

	// Load words leave one cycle after entering
	assign ext_out_req	= (ld_state == LD_RUN) && !empty;
	assign ext_out_data	= buff[rd_ptr];

	// Memory port
	assign mem.st_req	= (st_state == ST_WAIT) || (st_state == ST_RUN);
	assign mem.ld_req	= (ld_state == LD_WAIT) || ((ld_state == LD_RUN) && !ld_term_seen);
	assign mem.st_data	= buff[rd_ptr];
	assign mem.base		= base_r;
	assign mem.stride	= stride_r;
	assign mem.length	= length_r;

	////////////////////////////////////////////////////////////
	// Command header
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (ext_req) begin
			case (serv_state)
				SERV_INIT:			op_r		<= op_t'(ext_data[0]);
				SERV_RECV_STRIDE:	stride_r	<= ext_data[`MPU_WIDTH_ADDR-1:0];
				SERV_RECV_LENGTH:	length_r	<= ext_data[`MPU_WIDTH_ADDR-1:0];
				SERV_RECV_BASE:		base_r		<= ext_data[`MPU_WIDTH_ADDR-1:0];
				default:			base_r		<= base_r;	// Data words
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			serv_state	<= SERV_INIT;
		end
		else begin
			case (serv_state)
				SERV_INIT:			if (ext_req) serv_state	<= SERV_RECV_STRIDE;
				SERV_RECV_STRIDE:	if (ext_req) serv_state	<= SERV_RECV_LENGTH;
				SERV_RECV_LENGTH:	if (ext_req) serv_state	<= SERV_RECV_BASE;
				SERV_RECV_BASE:		if (ext_req) serv_state	<= SERV_RUN;
				SERV_RUN:			if (st_fin || ld_fin) serv_state	<= SERV_INIT;
				default:			serv_state	<= SERV_INIT;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Store and load control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			st_state	<= ST_IDLE;
		end
		else begin
			case (st_state)
				ST_IDLE: begin
					if (cmd_start && (op_r == OP_STORE)) begin
						st_state	<= ST_BUFF;
					end
				end
				ST_BUFF:	if (fill_last) st_state	<= ST_WAIT;		// Whole block held
				ST_WAIT:	if (mem.st_grant) st_state	<= ST_RUN;
				ST_RUN:		if (mem.st_term) st_state	<= ST_IDLE;
				default:	st_state	<= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ld_state	<= LD_IDLE;
		end
		else begin
			case (ld_state)
				LD_IDLE: begin
					if (cmd_start && (op_r == OP_LOAD)) begin
						ld_state	<= LD_WAIT;
					end
				end
				LD_WAIT:	if (mem.ld_grant) ld_state	<= LD_RUN;
				LD_RUN:		if (ld_fin) ld_state	<= LD_IDLE;		// Buffer drained
				default:	ld_state	<= LD_IDLE;
			endcase
		end
	end

	// Memory side of a load is over, buffer may still hold words
	always_ff @(posedge clock) begin
		if (reset) begin
			ld_term_seen	<= 1'b0;
		end
		else if (ld_fin) begin
			ld_term_seen	<= 1'b0;
		end
		else if (mem.ld_term) begin
			ld_term_seen	<= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			done	<= 1'b0;
		end
		else begin
			done	<= st_fin || ld_fin;
		end
	end

	// A store block has to fit in the buffer before the memory drains it
	a_st_length: assert property (@(posedge clock) disable iff (reset)
		(st_state == ST_BUFF) |-> (length_r <= addr_t'(BUFF_SIZE)));

endmodule

// File: hdl/data_memory.sv
////////////////////////////////////////////////////////////
// Data memory
// Grants one load or store request at a time and walks a
// strided address range, one word per cycle
////////////////////////////////////////////////////////////

`include "mpu_consts.svh"

module data_memory
	import mpu_pkg::*;
(
	input	logic			clock,
	input	logic			reset,
	mem_port_if.memory		mem
);

	fsm_mem_t	state;
	addr_t		addr_r;			// Base plus index times stride
	addr_t		idx;			// Words done so far
	logic		last_word;

	data_t		mem_array [`MPU_MEM_DEPTH];

	assign last_word	= (idx + addr_t'(1)) == mem.length;

	assign mem.st_term	= (state == MEM_STORE) && last_word;
	assign mem.ld_term	= (state == MEM_LOAD) && last_word;
	assign mem.ld_valid	= state == MEM_LOAD;
	assign mem.ld_data	= mem_array[addr_r];

	////////////////////////////////////////////////////////////
	// Grant and transfer control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state			<= MEM_IDLE;
			mem.st_grant	<= 1'b0;
			mem.ld_grant	<= 1'b0;
			idx				<= '0;
		end
		else begin
			mem.st_grant	<= 1'b0;
			mem.ld_grant	<= 1'b0;
			case (state)
				MEM_IDLE: begin
					idx	<= '0;
					// Transfer starts the cycle after the grant
					if (mem.ld_grant) begin
						state	<= MEM_LOAD;
					end
					else if (mem.st_grant) begin
						state	<= MEM_STORE;
					end
					else if (mem.ld_req) begin
						mem.ld_grant	<= 1'b1;		// Load first
					end
					else if (mem.st_req) begin
						mem.st_grant	<= 1'b1;
					end
				end
				MEM_STORE, MEM_LOAD: begin
					idx	<= idx + 1'b1;
					if (last_word) begin
						state	<= MEM_IDLE;
					end
				end
				default: begin
					state	<= MEM_IDLE;
				end
			endcase
		end
	end

	// Address walk wraps at the memory depth
	always_ff @(posedge clock) begin
		if (state == MEM_IDLE) begin
			addr_r	<= mem.base;
		end
		else begin
			addr_r	<= addr_r + mem.stride;
		end
	end

	always_ff @(posedge clock) begin
		if (state == MEM_STORE) begin
			mem_array[addr_r]	<= mem.st_data;
		end
	end

	// Load and store requests never compete for a grant
	a_one_req: assert property (@(posedge clock) disable iff (reset)
		!(mem.st_req && mem.ld_req));

endmodule

// File: hdl/mpu_extern_top.sv
////////////////////////////////////////////////////////////
// MPU external data top level
// Data service and data memory joined by the memory port
////////////////////////////////////////////////////////////

module mpu_extern_top
	import mpu_pkg::*;
(
	input	logic	clock,
	input	logic	reset,
	input	logic	ext_req,
	input	data_t	ext_data,
	output	logic	ext_out_req,
	output	data_t	ext_out_data,
	output	logic	busy,
	output	logic	done
);

	mem_port_if mem_bus ();

	// Command side
	extern_data_service u_service (
		.clock			(clock),
		.reset			(reset),
		.ext_req		(ext_req),
		.ext_data		(ext_data),
		.ext_out_req	(ext_out_req),
		.ext_out_data	(ext_out_data),
		.busy			(busy),
		.done			(done),
		.mem			(mem_bus.service)
	);

	// Storage side
	data_memory u_memory (
		.clock			(clock),
		.reset			(reset),
		.mem			(mem_bus.memory)
	);

endmodule

// File: tb/tb_mpu_extern.sv
////////////////////////////////////////////////////////////
// Testbench for the MPU external data service
// Strided store and load commands checked against a
// reference memory and an outbound word queue
////////////////////////////////////////////////////////////

`include "mpu_consts.svh"

module tb_mpu_extern
	import mpu_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// Data plus header words over all tests times a per-word bound
	localparam int TEST_WORDS		= 174;
	localparam int CYCLES_PER_WORD	= 12;
	localparam int WATCHDOG_CYCLES	= TEST_WORDS * CYCLES_PER_WORD;

	logic	clock;
	logic	reset;
	logic	ext_req;
	data_t	ext_data;
	logic	ext_out_req;
	data_t	ext_out_data;
	logic	busy;
	logic	done;

	data_t	ref_mem [`MPU_MEM_DEPTH];	// Written by every store issued
	data_t	exp_q [$];					// Outbound words still due
	data_t	exp_head;
	logic	exp_valid;
	logic	seen_req;					// First ext_req driven
	int		seed = 96;
	int		errors;
	int		done_count;
	int		err_mark;
	int		done_mark;
	int		test_num;
	int		tests_failed;

	mpu_extern_top DUT (
		.clock			(clock),
		.reset			(reset),
		.ext_req		(ext_req),
		.ext_data		(ext_data),
		.ext_out_req	(ext_out_req),
		.ext_out_data	(ext_out_data),
		.busy			(busy),
		.done			(done)
	);

	initial clock = 1'b0;
	always #20 clock = ~clock;

	// Outputs are stable at the falling edge
	always @(negedge clock) begin
		if (ext_out_req) begin
			exp_valid = exp_q.size() > 0;
			if (exp_valid) begin
				exp_head = exp_q.pop_front();		// Due at the next rising edge
			end
		end
		if (done) begin
			done_count++;
		end
	end

	////////////////////////////////////////////////////////////
	// Assertions
	////////////////////////////////////////////////////////////

	a_out_data: assert property (@(posedge clock) disable iff (reset)
		ext_out_req |-> (exp_valid && ext_out_data == exp_head))
	else begin
		if (!exp_valid) begin
			$display("Outbound word %h arrived with no load word expected",
				$sampled(ext_out_data));
		end
		else begin
			$display("CHECK FAILED: ext_out_data = %h, expected %h",
				$sampled(ext_out_data), exp_head);
		end
		errors++;
	end

	a_idle: assert property (@(posedge clock) disable iff (reset)
		!seen_req |-> !(ext_out_req || busy || done))
	else begin
		$display("CHECK FAILED: {ext_out_req,busy,done} = %h, expected 0",
			$sampled({ext_out_req, busy, done}));
		errors++;
	end

	// Opcode word starts a command
	a_busy_rise: assert property (@(posedge clock) disable iff (reset)
		(ext_req && !busy) |=> busy)
	else begin
		$display("CHECK FAILED: busy = %h, expected 1", $sampled(busy));
		errors++;
	end

	a_done_busy: assert property (@(posedge clock) disable iff (reset)
		done |-> (!busy && $past(busy)))
	else begin
		$display("CHECK FAILED: busy = %h at done, expected 0 after 1", $sampled(busy));
		errors++;
	end

	a_done_pulse: assert property (@(posedge clock) disable iff (reset)
		done |=> !done)
	else begin
		$display("CHECK FAILED: done = %h, expected 0 after one cycle", $sampled(done));
		errors++;
	end

	////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////

	task automatic drive_word(input data_t w);
		ext_req		= 1'b1;
		ext_data	= w;
		seen_req	= 1'b1;
		@(posedge clock);
		#2;
	endtask

	task automatic send_header(input op_t op, input addr_t stride, input addr_t length,
		input addr_t base);
		drive_word(data_t'(op));
		drive_word(data_t'(stride));
		drive_word(data_t'(length));
		drive_word(data_t'(base));
	endtask

	task automatic wait_done(input int limit);
		int start;
		int n;
		start	= done_count;
		n		= 0;
		ext_req	= 1'b0;
		while (done_count == start && n < limit) begin
			@(posedge clock);
			#2;
			n++;
		end
		if (done_count == start) begin
			$display("Command did not finish within %0d cycles", limit);
			errors++;
		end
	endtask

	task automatic store_block(input addr_t stride, input addr_t length, input addr_t base);
		data_t w;
		addr_t addr;
		send_header(OP_STORE, stride, length, base);
		for (int i = 0; i < int'(length); i++) begin
			w		= $random(seed);
			addr	= addr_t'(int'(base) + i * int'(stride));	// Wraps at the depth
			ref_mem[addr] = w;
			drive_word(w);
			if (i % 3 == 2) begin
				ext_req = 1'b0;		// Sender pauses now and then
				@(posedge clock);
				#2;
			end
		end
		wait_done(8 * int'(length) + 32);
	endtask

	task automatic load_block(input addr_t stride, input addr_t length, input addr_t base);
		for (int i = 0; i < int'(length); i++) begin
			exp_q.push_back(ref_mem[addr_t'(int'(base) + i * int'(stride))]);
		end
		send_header(OP_LOAD, stride, length, base);
		wait_done(4 * int'(length) + 32);
		if (exp_q.size() != 0) begin
			$display("Load at base %h left %0d words undelivered", base, exp_q.size());
			errors++;
			exp_q.delete();
		end
	endtask

	task automatic start_test();
		err_mark	= errors;
		done_mark	= done_count;
	endtask

	task automatic finish_test(input string name, input int cmds);
		if (done_count - done_mark != cmds) begin
			$display("CHECK FAILED: done pulses = %h, expected %h", done_count - done_mark, cmds);
			errors++;
		end
		test_num++;
		if (errors == err_mark) begin
			$display("Test %0d %s: ok", test_num, name);
		end
		else begin
			tests_failed++;
			$display("Test %0d %s: %0d errors", test_num, name, errors - err_mark);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		reset			= 1'b1;
		ext_req			= 1'b0;
		ext_data		= '0;
		seen_req		= 1'b0;
		exp_valid		= 1'b0;
		exp_head		= '0;
		errors			= 0;
		done_count		= 0;
		test_num		= 0;
		tests_failed	= 0;
		repeat (4) @(posedge clock);
		#2;
		reset = 1'b0;

		start_test();
		repeat (6) @(posedge clock);
		#2;
		finish_test("idle after reset", 0);

		start_test();
		store_block(8'd1, 8'd8, 8'd16);
		load_block(8'd1, 8'd8, 8'd16);
		finish_test("store and load stride 1", 2);

		start_test();
		store_block(8'd1, 8'd13, 8'd40);		// Background over the span
		store_block(8'd3, 8'd5, 8'd40);
		load_block(8'd3, 8'd5, 8'd40);
		load_block(8'd1, 8'd13, 8'd40);
		finish_test("stride 3", 4);

		start_test();
		store_block(8'd2, 8'd8, 8'd96);
		store_block(8'd1, 8'd8, 8'd252);		// Wraps past the top
		load_block(8'd2, 8'd8, 8'd96);
		load_block(8'd1, 8'd8, 8'd252);
		finish_test("disjoint blocks", 4);

		start_test();
		store_block(8'd1, 8'd1, 8'd200);
		load_block(8'd1, 8'd1, 8'd200);
		store_block(8'd1, addr_t'(`MPU_BUFF_SIZE), 8'd120);
		load_block(8'd1, addr_t'(`MPU_BUFF_SIZE), 8'd120);
		finish_test("length 1 and full buffer", 4);

		$display("Totals: %0d tests, %0d failed, %0d errors", test_num, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end
		else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: sources.f
+incdir+hdl
hdl/mpu_pkg.sv
hdl/mem_port_if.sv
hdl/ring_buff_ctrl.sv
hdl/extern_data_service.sv
hdl/data_memory.sv
hdl/mpu_extern_top.sv
tb/tb_mpu_extern.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator.
# The run passes only if the pass message shows up in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_mpu_extern \
	&& ./obj_dir/Vtb_mpu_extern | tee /dev/stderr | grep -q "Simulation finished: PASS" \
	&& echo "run_sim: passed" \
	|| { echo "run_sim: failed"; exit 1; }
